// File: rtl/conv_pkg.sv
// Shared types for the 1D convolution engine

package conv_pkg;

    ////////////////////////////////////////////////////////////////////
    // Command opcodes from the outside
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        // Idle slot, nothing happens
        OP_NOP     = 2'd0,
        // Write one weight into one channel
        OP_LOAD_WT = 2'd1,
        // One input sample for all channels
        OP_SAMPLE  = 2'd2,
        // Drop current window, zero accumulators
        OP_CLEAR   = 2'd3
    } cmd_op_e;

    ////////////////////////////////////////////////////////////////////
    // Output serializer states
    ////////////////////////////////////////////////////////////////////

    typedef enum logic {
        DRAIN_IDLE  = 1'b0,
        DRAIN_SHIFT = 1'b1
    } drain_state_e;

endpackage

// File: rtl/pe_feed_if.sv
`timescale 1ns/10ps

// Broadcast from the feeder to every processing element
interface pe_feed_if #(
    parameter int DATA_WIDTH = 16,
    parameter int N_PE       = 4,
    parameter int MAX_K      = 8
);

    // Sample stream
    logic                         smp_valid;
    // Last tap of the current window
    logic                         smp_last;
    logic [$clog2(MAX_K)-1:0]     smp_tap;
    logic signed [DATA_WIDTH-1:0] smp_data;

    // Weight write, one channel selected by wt_pe
    logic                         wt_we;
    logic [$clog2(N_PE)-1:0]      wt_pe;
    logic [$clog2(MAX_K)-1:0]     wt_tap;
    logic signed [DATA_WIDTH-1:0] wt_data;

    // Abandon window, zero both pipeline stages
    logic                         clear;

    modport feeder (
        output smp_valid, smp_last, smp_tap, smp_data,
        output wt_we, wt_pe, wt_tap, wt_data,
        output clear
    );

    modport pe (
        input smp_valid, smp_last, smp_tap, smp_data,
        input wt_we, wt_pe, wt_tap, wt_data,
        input clear
    );

endinterface

// File: rtl/conv_feeder.sv
`timescale 1ns/10ps

module conv_feeder #(
    parameter int DATA_WIDTH = 16,
    parameter int N_PE       = 4,
    parameter int MAX_K      = 8
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         cmd_valid,
    input  conv_pkg::cmd_op_e            cmd_op,
    input  logic [$clog2(N_PE)-1:0]      cmd_pe,
    input  logic [$clog2(MAX_K)-1:0]     cmd_tap,
    input  logic [DATA_WIDTH-1:0]        cmd_data,
    input  logic [$clog2(MAX_K+1)-1:0]   kernel_size,
    pe_feed_if.feeder                    feed
);
    import conv_pkg::*;

    localparam int TAP_W = $clog2(MAX_K);
    localparam int KS_W  = $clog2(MAX_K+1);

    // Position of the next sample inside the window
    logic [TAP_W-1:0] tap_cnt;
    logic             tap_is_last;

    // One-hot command decode
    logic             is_sample;
    logic             is_load;
    logic             is_clear;

    ////////////////////////////////////////////////////////////////////
    // Command decode
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        is_sample = 1'b0;
        is_load   = 1'b0;
        is_clear  = 1'b0;
        case (cmd_op)
            OP_SAMPLE:  is_sample = cmd_valid;
            OP_LOAD_WT: is_load   = cmd_valid;
            OP_CLEAR:   is_clear  = cmd_valid;
            // OP_NOP falls through, nothing to broadcast
            default: ;
        endcase
    end

    // Window ends on tap kernel_size-1
    assign tap_is_last = (KS_W'(tap_cnt) == (kernel_size - KS_W'(1)));

    ////////////////////////////////////////////////////////////////////
    // Strobes and tap counter
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            feed.smp_valid <= 1'b0;
            feed.smp_last  <= 1'b0;
            feed.wt_we     <= 1'b0;
            feed.clear     <= 1'b0;
            tap_cnt        <= '0;
        end else begin
            feed.smp_valid <= is_sample;
            feed.smp_last  <= is_sample & tap_is_last;
            feed.wt_we     <= is_load;
            feed.clear     <= is_clear;
            // Clear restarts the window at tap 0
            if (is_clear) begin
                tap_cnt <= '0;
            end else if (is_sample) begin
                tap_cnt <= tap_is_last ? '0 : tap_cnt + 1'b1;
            end
        end
    end

    // Payload fields, only meaningful with their strobe
    always_ff @(posedge clk) begin
        if (is_sample) begin
            feed.smp_tap  <= tap_cnt;
            feed.smp_data <= cmd_data;
        end
        if (is_load) begin
            feed.wt_pe   <= cmd_pe;
            feed.wt_tap  <= cmd_tap;
            feed.wt_data <= cmd_data;
        end
    end

endmodule

// File: rtl/conv_pe.sv
`timescale 1ns/10ps

module conv_pe #(
    parameter int DATA_WIDTH = 16,
    parameter int N_PE       = 4,
    parameter int MAX_K      = 8,
    parameter int ACC_WIDTH  = 35,
    parameter int PE_ID      = 0
) (
    input  logic                        clk,
    input  logic                        rstn,
    pe_feed_if.pe                       feed,
    output logic                        res_valid,
    output logic signed [ACC_WIDTH-1:0] res_data
);

    localparam int              PE_W   = $clog2(N_PE);
    localparam int              PROD_W = 2*DATA_WIDTH;
    localparam logic [PE_W-1:0] MY_ID  = PE_W'(PE_ID);

    // Filter taps of this channel
    logic signed [DATA_WIDTH-1:0] wt_mem [MAX_K];
    logic signed [DATA_WIDTH-1:0] wt_sel;

    // Stage 1, registered product
    logic signed [PROD_W-1:0]     prod;
    logic signed [ACC_WIDTH-1:0]  prod_ext;
    logic                         prod_vld;
    logic                         prod_last;

    // Stage 2, window accumulator
    logic signed [ACC_WIDTH-1:0]  acc;
    // Next product opens a new window
    logic                         acc_restart;

    ////////////////////////////////////////////////////////////////////
    // Weight registers
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int k = 0; k < MAX_K; k++) begin
                wt_mem[k] <= '0;
            end
        end else if (feed.wt_we && (feed.wt_pe == MY_ID)) begin
            wt_mem[feed.wt_tap] <= feed.wt_data;
        end
    end

    assign wt_sel = wt_mem[feed.smp_tap];

    ////////////////////////////////////////////////////////////////////
    // Multiply then accumulate
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prod      <= '0;
            prod_vld  <= 1'b0;
            prod_last <= 1'b0;
        end else if (feed.clear) begin
            // Pending last is dropped here
            prod      <= '0;
            prod_vld  <= 1'b0;
            prod_last <= 1'b0;
        end else begin
            prod_vld  <= feed.smp_valid;
            prod_last <= feed.smp_valid & feed.smp_last;
            if (feed.smp_valid) begin
                prod <= feed.smp_data * wt_sel;
            end
        end
    end

    // Sign extend to accumulator width
    assign prod_ext = {{(ACC_WIDTH-PROD_W){prod[PROD_W-1]}}, prod};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc         <= '0;
            acc_restart <= 1'b0;
            res_valid   <= 1'b0;
        end else if (feed.clear) begin
            acc         <= '0;
            acc_restart <= 1'b0;
            res_valid   <= 1'b0;
        end else begin
            res_valid <= prod_vld & prod_last;
            if (prod_vld) begin
                // First product of a window replaces the old sum
                acc         <= acc_restart ? prod_ext : acc + prod_ext;
                acc_restart <= prod_last;
            end
        end
    end

    // Sum is stable while res_valid is high
    assign res_data = acc;

endmodule

// File: rtl/conv_drain.sv
`timescale 1ns/10ps

module conv_drain #(
    parameter int N_PE      = 4,
    parameter int ACC_WIDTH = 35
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [N_PE-1:0]                   res_valid,
    input  logic [N_PE-1:0][ACC_WIDTH-1:0]    res_data,
    output logic                              out_valid,
    output logic [$clog2(N_PE)-1:0]           out_ch,
    output logic signed [ACC_WIDTH-1:0]       out_data
);
    import conv_pkg::*;

    localparam int CH_W = $clog2(N_PE);

    drain_state_e                   state;
    // Results of one window, one entry per channel
    logic [N_PE-1:0][ACC_WIDTH-1:0] bank;

    ////////////////////////////////////////////////////////////////////
    // Serializer FSM
    ////////////////////////////////////////////////////////////////////

    // Last output cycle already sits in DRAIN_IDLE,
    // so back-to-back windows load without a gap
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= DRAIN_IDLE;
            out_valid <= 1'b0;
            out_ch    <= '0;
        end else begin
            case (state)
                DRAIN_IDLE: begin
                    // All channels end together, channel 0 stands for all
                    if (res_valid[0]) begin
                        out_valid <= 1'b1;
                        out_ch    <= '0;
                        state     <= DRAIN_SHIFT;
                    end else begin
                        out_valid <= 1'b0;
                    end
                end
                DRAIN_SHIFT: begin
                    out_ch <= out_ch + 1'b1;
                    // Leave one cycle before the last channel goes out
                    if (out_ch == CH_W'(N_PE-2)) begin
                        state <= DRAIN_IDLE;
                    end
                end
                default: state <= DRAIN_IDLE;
            endcase
        end
    end

    // Result bank, loaded once per window
    always_ff @(posedge clk) begin
        if ((state == DRAIN_IDLE) && res_valid[0]) begin
            bank <= res_data;
        end
    end

    assign out_data = $signed(bank[out_ch]);

endmodule

// File: rtl/conv_array.sv
`timescale 1ns/10ps

module conv_array #(
    parameter int DATA_WIDTH = 16,
    parameter int N_PE       = 4,
    parameter int MAX_K      = 8,
    parameter int ACC_WIDTH  = 35
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        cmd_valid,
    input  conv_pkg::cmd_op_e           cmd_op,
    input  logic [$clog2(N_PE)-1:0]     cmd_pe,
    input  logic [$clog2(MAX_K)-1:0]    cmd_tap,
    input  logic [DATA_WIDTH-1:0]       cmd_data,
    input  logic [$clog2(MAX_K+1)-1:0]  kernel_size,
    output logic                        out_valid,
    output logic [$clog2(N_PE)-1:0]     out_ch,
    output logic signed [ACC_WIDTH-1:0] out_data
);

    // Per-channel results towards the drain
    logic [N_PE-1:0]                res_valid;
    logic [N_PE-1:0][ACC_WIDTH-1:0] res_data;

    ////////////////////////////////////////////////////////////////////
    // Feeder drives the shared broadcast
    ////////////////////////////////////////////////////////////////////

    pe_feed_if #(.DATA_WIDTH(DATA_WIDTH), .N_PE(N_PE), .MAX_K(MAX_K)) feed_if ();

    conv_feeder #(.DATA_WIDTH(DATA_WIDTH), .N_PE(N_PE), .MAX_K(MAX_K)) feeder_i (
        .clk         (clk),
        .rstn        (rstn),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_pe      (cmd_pe),
        .cmd_tap     (cmd_tap),
        .cmd_data    (cmd_data),
        .kernel_size (kernel_size),
        .feed        (feed_if.feeder)
    );

    // One element per output channel
    for (genvar i = 0; i < N_PE; i++) begin : g_pe
        conv_pe #(
            .DATA_WIDTH (DATA_WIDTH),
            .N_PE       (N_PE),
            .MAX_K      (MAX_K),
            .ACC_WIDTH  (ACC_WIDTH),
            .PE_ID      (i)
        ) pe_i (
            .clk       (clk),
            .rstn      (rstn),
            .feed      (feed_if.pe),
            .res_valid (res_valid[i]),
            .res_data  (res_data[i])
        );
    end

    conv_drain #(.N_PE(N_PE), .ACC_WIDTH(ACC_WIDTH)) drain_i (
        .clk       (clk),
        .rstn      (rstn),
        .res_valid (res_valid),
        .res_data  (res_data),
        .out_valid (out_valid),
        .out_ch    (out_ch),
        .out_data  (out_data)
    );

endmodule

// File: bench/conv_chk.sv
`timescale 1ns/10ps

module conv_chk #(
    parameter int N_PE  = 4,
    parameter int MAX_K = 8
) (
    input logic                         clk,
    input logic                         rstn,
    input conv_pkg::drain_state_e       state,
    input logic [N_PE-1:0]              res_valid,
    input logic                         smp_last,
    input logic [$clog2(MAX_K)-1:0]     smp_tap,
    input logic [$clog2(MAX_K+1)-1:0]   kernel_size
);
    import conv_pkg::*;

    localparam int KS_W = $clog2(MAX_K+1);

    // Drain busy means no new window may finish
    a_no_res_in_shift: assert property (@(posedge clk) disable iff (!rstn)
        (state == DRAIN_SHIFT) |-> (res_valid == '0))
        else $error("res_valid arrived while the drain was shifting");

    // Every channel ends its window on the same cycle
    a_res_aligned: assert property (@(posedge clk) disable iff (!rstn)
        (res_valid == '0) || (res_valid == '1))
        else $error("res_valid bits disagree across channels");

    // Last flag only on the final tap for the kernel size of that sample
    a_last_tap: assert property (@(posedge clk) disable iff (!rstn)
        smp_last |-> (KS_W'(smp_tap) == ($past(kernel_size) - KS_W'(1))))
        else $error("smp_last on a tap other than kernel_size-1");

endmodule

////////////////////////////////////////////////////////////////////////
// Attached to drain and feeder with the unused side tied off
////////////////////////////////////////////////////////////////////////

bind conv_drain conv_chk #(.N_PE(N_PE)) drain_chk_i (
    .clk         (clk),
    .rstn        (rstn),
    .state       (state),
    .res_valid   (res_valid),
    .smp_last    (1'b0),
    .smp_tap     ('0),
    .kernel_size ('0)
);

bind conv_feeder conv_chk #(.N_PE(N_PE), .MAX_K(MAX_K)) feeder_chk_i (
    .clk         (clk),
    .rstn        (rstn),
    .state       (conv_pkg::DRAIN_IDLE),
    .res_valid   ('0),
    .smp_last    (feed.smp_last),
    .smp_tap     (feed.smp_tap),
    .kernel_size (kernel_size)
);

// File: bench/conv_tb.sv
`timescale 1ns/10ps

module conv_tb;
    import conv_pkg::*;

    localparam int DATA_WIDTH = 16;
    localparam int N_PE       = 4;
    localparam int MAX_K      = 8;
    localparam int ACC_WIDTH  = 35;
    localparam int PE_W       = $clog2(N_PE);
    localparam int TAP_W      = $clog2(MAX_K);
    localparam int KS_W       = $clog2(MAX_K+1);
    // Bound on every wait for out_valid
    localparam int MAX_WAIT   = 50;
    localparam logic [DATA_WIDTH-1:0] MOST_NEG = {1'b1, {(DATA_WIDTH-1){1'b0}}};
    localparam logic [DATA_WIDTH-1:0] MOST_POS = {1'b0, {(DATA_WIDTH-1){1'b1}}};

    logic                        clk;
    logic                        rstn;
    logic                        cmd_valid;
    cmd_op_e                     cmd_op;
    logic [PE_W-1:0]             cmd_pe;
    logic [TAP_W-1:0]            cmd_tap;
    logic [DATA_WIDTH-1:0]       cmd_data;
    logic [KS_W-1:0]             kernel_size;
    logic                        out_valid;
    logic [PE_W-1:0]             out_ch;
    logic signed [ACC_WIDTH-1:0] out_data;

    integer seed = 38;
    int     ks_cur;

    // Model of all weight registers and of the current window
    logic signed [DATA_WIDTH-1:0] wt_model [N_PE][MAX_K];
    logic signed [DATA_WIDTH-1:0] win_smp  [MAX_K];
    // Outputs of one window as received
    int     got_ch   [$];
    longint got_data [$];

    conv_array #(
        .DATA_WIDTH (DATA_WIDTH),
        .N_PE       (N_PE),
        .MAX_K      (MAX_K),
        .ACC_WIDTH  (ACC_WIDTH)
    ) conv_array_i (
        .clk         (clk),
        .rstn        (rstn),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_pe      (cmd_pe),
        .cmd_tap     (cmd_tap),
        .cmd_data    (cmd_data),
        .kernel_size (kernel_size),
        .out_valid   (out_valid),
        .out_ch      (out_ch),
        .out_data    (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////////////

    task automatic check_eq(input string name, input longint exp, input longint act);
        if (exp !== act) begin
            $display("error: %s expected %0d actual %0d", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic send_cmd(input cmd_op_e op, input int pe, input int tap,
                            input logic [DATA_WIDTH-1:0] data);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_pe    <= PE_W'(pe);
        cmd_tap   <= TAP_W'(tap);
        cmd_data  <= data;
    endtask

    // No command, junk on the other fields
    task automatic idle_cycle();
        @(posedge clk);
        cmd_valid <= 1'b0;
        cmd_op    <= cmd_op_e'(2'($random(seed)));
        cmd_data  <= DATA_WIDTH'($random(seed));
    endtask

    task automatic set_kernel(input int ks);
        @(posedge clk);
        cmd_valid   <= 1'b0;
        kernel_size <= KS_W'(ks);
        ks_cur = ks;
    endtask

    task automatic load_weight(input int pe, input int tap, input logic [DATA_WIDTH-1:0] w);
        send_cmd(OP_LOAD_WT, pe, tap, w);
        wt_model[pe][tap] = w;
    endtask

    function automatic logic [DATA_WIDTH-1:0] pick_extreme();
        return ($random(seed) & 1) ? MOST_NEG : MOST_POS;
    endfunction

    // Up to 3 idle slots or NOPs
    task automatic random_gap();
        int n;
        n = $random(seed) & 3;
        repeat (n) begin
            if ($random(seed) & 1) begin
                send_cmd(OP_NOP, $random(seed), $random(seed), DATA_WIDTH'($random(seed)));
            end else begin
                idle_cycle();
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Reference model and window checks
    ////////////////////////////////////////////////////////////////////

    // Full width dot product of filter and window
    function automatic longint window_sum(input int ch);
        longint sum;
        sum = 0;
        for (int k = 0; k < ks_cur; k++) begin
            sum += longint'(wt_model[ch][k]) * longint'(win_smp[k]);
        end
        return sum;
    endfunction

    task automatic collect_window(input string name);
        int lat;
        lat = 0;
        // Edge that takes the last sample
        idle_cycle();
        for (int i = 1; i <= MAX_WAIT && lat == 0; i++) begin
            idle_cycle();
            @(negedge clk);
            if (out_valid) lat = i;
        end
        if (lat == 0) begin
            $display("Timeout, out_valid never rose for window %s", name);
            $display("Test failed");
            $fatal(1);
        end
        check_eq({name, " latency"}, longint'(3), longint'(lat));
        // One channel per cycle
        for (int ch = 0; ch < N_PE; ch++) begin
            check_eq({name, " out_valid"}, longint'(1), longint'(out_valid));
            got_ch.push_back(int'(out_ch));
            got_data.push_back(longint'(out_data));
            @(negedge clk);
        end
        check_eq({name, " out_valid after drain"}, longint'(0), longint'(out_valid));
        for (int ch = 0; ch < N_PE; ch++) begin
            check_eq($sformatf("%s ch%0d index", name, ch), longint'(ch),
                     longint'(got_ch.pop_front()));
            check_eq($sformatf("%s ch%0d data", name, ch), window_sum(ch),
                     got_data.pop_front());
        end
    endtask

    // Sample mode 0 random, 1 random extremes, 2 all most negative
    task automatic run_window(input string name, input bit gaps, input int mode);
        logic [DATA_WIDTH-1:0] smp;
        for (int k = 0; k < ks_cur; k++) begin
            case (mode)
                1: smp = pick_extreme();
                2: smp = MOST_NEG;
                default: smp = DATA_WIDTH'($random(seed));
            endcase
            win_smp[k] = smp;
            if (gaps) random_gap();
            send_cmd(OP_SAMPLE, 0, 0, smp);
        end
        collect_window(name);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        rstn        = 1'b0;
        cmd_valid   = 1'b0;
        cmd_op      = OP_NOP;
        cmd_pe      = '0;
        cmd_tap     = '0;
        cmd_data    = '0;
        kernel_size = KS_W'(N_PE);
        ks_cur      = N_PE;
        for (int pe = 0; pe < N_PE; pe++) begin
            for (int k = 0; k < MAX_K; k++) wt_model[pe][k] = '0;
        end
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        // Outputs stay quiet without commands
        repeat (10) begin
            @(negedge clk);
            check_eq("reset out_valid", longint'(0), longint'(out_valid));
        end

        // Random filters, samples back to back
        for (int pe = 0; pe < N_PE; pe++) begin
            for (int k = 0; k < MAX_K; k++) load_weight(pe, k, DATA_WIDTH'($random(seed)));
        end
        repeat (8) run_window("basic", 1'b0, 0);

        // Gaps between samples, one weight changed per window
        repeat (6) begin
            load_weight($random(seed) & (N_PE-1), $random(seed) & (N_PE-1),
                        DATA_WIDTH'($random(seed)));
            run_window("gaps", 1'b1, 0);
        end

        // Abandoned window must leave no trace
        set_kernel(6);
        repeat (3) send_cmd(OP_SAMPLE, 0, 0, DATA_WIDTH'($random(seed)));
        send_cmd(OP_CLEAR, 0, 0, '0);
        repeat (12) begin
            idle_cycle();
            @(negedge clk);
            check_eq("clear no output", longint'(0), longint'(out_valid));
        end
        run_window("after clear", 1'b0, 0);

        // Signed extremes at the largest kernel, channel 0 all most negative
        set_kernel(MAX_K);
        for (int pe = 0; pe < N_PE; pe++) begin
            for (int k = 0; k < MAX_K; k++) begin
                load_weight(pe, k, (pe == 0) ? MOST_NEG : pick_extreme());
            end
        end
        run_window("extreme neg", 1'b0, 2);
        repeat (6) run_window("extreme", 1'b0, 1);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: src.f
rtl/conv_pkg.sv
rtl/pe_feed_if.sv
rtl/conv_feeder.sv
rtl/conv_pe.sv
rtl/conv_drain.sv
rtl/conv_array.sv
bench/conv_chk.sv
bench/conv_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the convolution engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module conv_tb -Mdir obj_dir -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vconv_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0
